//--- Bender.yml
package:
  name: adc_fe

export_include_dirs:
  - .

sources:
  - adc_fe_pkg.sv
  - adc_capture.sv
  - adc_lane.sv
  - trig_router.sv
  - exp_pin_mux.sv
  - adc_fe_top.sv
  - target: test
    files:
      - tb_clkgen.sv
      - adc_fe_checker.sv
      - adc_fe_tb.sv

//--- adc_capture.sv
// ADC capture stage
// retimes the four raw converter words into the core clock domain
// and holds sample validity low until SPI setup and PLL lock are both in

`timescale 1ns/100ps
`default_nettype none

`include "adc_fe_macros.svh"

module adc_capture (
  input  logic                                   adc_clk_01,
  input  logic                                   rst_n_i,
  // raw words, already captured at the pins
  input  adc_fe_pkg::adc_raw_t [`ADC_CHN-1:0]    adc_raw_i,
  input  logic                                   spi_done_i,   // converter setup done
  input  logic                                   pll_locked_i, // sample clock stable
  // to the lanes
  output adc_fe_pkg::adc_raw_t [`ADC_CHN-1:0]    raw_o,
  output logic                                   raw_vld_o
);

  //////////////////////////////////////////////////
  // raw word register, one stage for all lanes

  always_ff @(posedge adc_clk_01 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      raw_o <= '0;  // samples read zero out of reset
    end else begin
      raw_o <= adc_raw_i;
    end
  end

  //////////////////////////////////////////////////
  // sample validity gate

  // words are garbage until the converter is set up and
  // the clock has settled, so validity follows both
  always_ff @(posedge adc_clk_01 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      raw_vld_o <= 1'b0;
    end else begin
      raw_vld_o <= spi_done_i & pll_locked_i;  // lines up with raw_o
    end
  end

endmodule : adc_capture

`default_nettype wire

//--- adc_fe_checker.sv
// ADC front end protocol checker
// reset quiet outputs, single cycle lane triggers, valid latency

`timescale 1ns/100ps
`default_nettype none

`include "adc_fe_macros.svh"

module adc_fe_checker (
  input  logic                 adc_clk_01,
  input  logic                 rst_n_i,
  input  logic                 spi_done_i,
  input  logic                 pll_locked_i,
  input  logic                 adc_vld_i,
  input  logic                 scope_trig_i,
  input  logic                 trig_ext_i,
  input  logic                 trig_out_i,
  input  logic [`ADC_CHN-1:0]  trig_ch_i
);

  int n_fail = 0;  // failed assertions so far

  // registered outputs stay quiet while held in reset
  reset_quiet : assert property (@(posedge adc_clk_01)
    (!rst_n_i && $past(!rst_n_i)) |->
      !(adc_vld_i | scope_trig_i | trig_ext_i | trig_out_i))
    else begin
      n_fail++;
      $error("outputs active during reset");
    end

  // each lane crossing flag is a single pulse
  for (genvar i = 0; i < `ADC_CHN; i++) begin : g_pulse
    trig_pulse : assert property (@(posedge adc_clk_01) disable iff (!rst_n_i)
      trig_ch_i[i] |=> !trig_ch_i[i])
      else begin
        n_fail++;
        $error("lane trigger held longer than one cycle");
      end
  end

  // one capture stage and two lane stages
  vld_latency : assert property (@(posedge adc_clk_01) disable iff (!rst_n_i)
    $rose(spi_done_i && pll_locked_i) |-> ##3 $rose(adc_vld_i))
    else begin
      n_fail++;
      $error("sample valid did not rise three cycles after setup and lock");
    end

endmodule : adc_fe_checker

bind adc_fe_top adc_fe_checker u_checker (
  .adc_clk_01   (adc_clk_01),
  .rst_n_i      (rst_n_i),
  .spi_done_i   (spi_done_i),
  .pll_locked_i (pll_locked_i),
  .adc_vld_i    (adc_vld_o),
  .scope_trig_i (scope_trig_o),
  .trig_ext_i   (trig_ext_o),
  .trig_out_i   (trig_out_o),
  .trig_ch_i    (trig_ch)
);

`default_nettype wire

//--- adc_fe_input.txt
# raw0 raw1 raw2 raw3 level ch_en daisy_mode daisy_word asg spi_done pll_locked
# exp_p exp_n_out exp_n_dir can_on can0_tx can1_tx cross_flags (all hex)
3000 3000 3000 3000 0000 f 0 0000 0 0 0 001 155 0ff 0 0 0 0
1000 1000 1000 1000 0000 f 0 0000 1 1 0 0c1 2aa 700 0 1 1 0
3000 3000 3000 3000 0000 f 4 0000 1 0 1 7ff 000 7ff 1 1 0 0
3000 3000 3000 3000 0000 f 0 0000 0 1 1 000 7ff 000 1 0 1 0
1000 3000 1000 3000 0000 f 0 0000 0 1 1 001 123 456 0 0 0 5
1800 0000 3fff 1fff 0000 f 1 0001 0 1 1 001 321 654 0 0 0 a
3000 3000 2000 3000 0000 f 1 0000 0 1 1 001 0f0 00f 0 0 0 0
0fff 2fff 1fff 3000 0000 f 0 8000 0 1 1 001 000 000 0 0 0 5
3000 1000 3000 1000 0000 f 0 0000 0 0 1 000 000 000 0 0 0 0
1000 1000 1000 1000 0000 f 2 0000 0 1 1 0c0 3ff 3ff 1 1 0 a
3000 3000 3000 3000 0000 3 2 0000 1 1 1 0c0 000 7ff 1 0 1 0
1000 1000 1000 1000 0000 3 6 0000 1 1 1 080 555 2aa 0 1 1 f
3000 3000 3000 3000 0000 3 4 0000 0 1 1 040 2aa 555 1 1 1 0
1000 1000 1000 1000 0000 3 4 0000 1 1 1 000 000 000 0 0 0 f
3000 3000 3000 3000 0000 3 0 0000 0 1 1 001 000 000 0 0 0 0
1000 1000 1000 1000 0000 3 0 0000 0 1 1 001 000 000 0 0 0 f
1000 1000 1000 1000 0000 4 0 0000 0 1 1 000 000 000 0 0 0 0
3000 3000 3000 3000 0000 4 2 0000 0 1 1 000 000 000 0 0 0 0
3000 3000 3000 3000 0000 4 2 0000 0 1 1 001 000 000 0 0 0 0
0000 0000 0000 0000 0000 4 2 0000 0 1 1 001 000 000 0 0 0 f
1000 1000 1000 1000 0000 f 3 ffff 0 1 1 001 7ff 7ff 0 0 0 0
1000 1000 1000 1000 0000 f 1 0000 1 1 1 001 000 7ff 1 1 1 0
1000 1000 1000 1000 0000 f 5 0100 1 1 1 0c1 7ff 000 1 0 0 0
1000 1000 1000 1000 0000 f 0 0000 0 1 1 000 000 000 0 0 0 0
3000 3000 3000 3000 0000 f 0 0000 0 1 1 000 000 000 0 0 0 0
0000 3000 1fff 3fff 0000 f 0 0000 0 1 1 000 000 000 0 0 0 5

//--- adc_fe_macros.svh
// ADC front end widths and counts
// shared by the sample path, trigger routing and expansion pin logic

`ifndef ADC_FE_MACROS_SVH
`define ADC_FE_MACROS_SVH

//////////////////////////////////////////////////
// sample path
`define ADC_CHN   4   // acquisition channels
`define ADC_DW    14  // converter word width

//////////////////////////////////////////////////
// expansion connector, one side
`define EXP_DW    11
`define CAN0_PIN  7   // CAN 0 tx on n, rx on p
`define CAN1_PIN  6   // CAN 1 tx on n, rx on p
`define TRIG_PIN  0   // trigger alternate bit

//////////////////////////////////////////////////
// daisy chain received word
`define DAISY_DW  16

`endif

//--- adc_fe_pkg.sv
// ADC front end types
// raw converter codes, signed samples and the daisy mode word

`default_nettype none

`include "adc_fe_macros.svh"

package adc_fe_pkg;

  //////////////////////////////////////////////////
  // sample words

  // offset binary, negative slope, as captured
  typedef logic [`ADC_DW-1:0] adc_raw_t;

  // two's complement after conversion
  typedef logic signed [`ADC_DW-1:0] adc_smp_t;

  //////////////////////////////////////////////////
  // daisy mode, msb first
  typedef struct packed {
    logic trig_out_asg;  // bit 2, generator trigger goes out
    logic trig_pin_alt;  // bit 1, n bit 0 turns into trigger pin
    logic sync_en;       // bit 0, daisy sync mode
  } daisy_mode_t;

endpackage : adc_fe_pkg

`default_nettype wire

//--- adc_fe_tb.sv
// ADC front end testbench
// file vectors then seeded random raw codes, checked against a cycle model

`timescale 1ns/100ps
`default_nettype none

`include "adc_fe_macros.svh"

module adc_fe_tb;

  localparam int OFS = 8;  // entries below OFS stand for the idle inputs before the run
  localparam int DEPTH = 256;
  localparam int NRAND = 12;
  localparam int NDRAIN = 8;
  localparam bit [`ADC_DW-1:0] DRAIN_LVL = 14'h0800;  // raised threshold for the tail

  logic adc_clk_01, rst_n;
  adc_fe_pkg::adc_raw_t [`ADC_CHN-1:0] adc_raw;
  adc_fe_pkg::adc_smp_t [`ADC_CHN-1:0] adc_dat;
  adc_fe_pkg::adc_smp_t trig_level;
  adc_fe_pkg::daisy_mode_t daisy_mode;
  logic [`ADC_CHN-1:0] trig_ch_en;
  logic [`DAISY_DW-1:0] daisy_dat;
  logic [`EXP_DW-1:0] exp_p, exp_n, exp_n_out, exp_n_dir, exp_n_q, exp_n_oe;
  logic spi_done, pll_locked, asg_trig, can_on, can0_tx, can1_tx;
  logic adc_vld, scope_trig, trig_ext, trig_out, can0_rx, can1_rx;

  // vector store, one entry per driven cycle
  bit [`ADC_DW-1:0] raw_a [DEPTH][`ADC_CHN];
  bit [`ADC_DW-1:0] lvl_a [DEPTH];
  bit [3:0] en_a [DEPTH], flag_a [DEPTH], cross_a [DEPTH];
  bit [2:0] md_a [DEPTH];
  bit [15:0] dz_a [DEPTH];
  bit [10:0] p_a [DEPTH], no_a [DEPTH], nd_a [DEPTH];
  bit asg_a [DEPTH], spi_a [DEPTH], pll_a [DEPTH], has_flag [DEPTH];
  bit can_a [DEPTH], c0_a [DEPTH], c1_a [DEPTH];
  int n_vec, n_cyc, n_err, n_checks, cyc_cnt;
  int limit = 100000;
  bit file_ok;

  tb_clkgen u_clkgen (.adc_clk_01(adc_clk_01), .rst_n_o(rst_n));

  adc_fe_top dut0 (
    .adc_clk_01(adc_clk_01), .rst_n_i(rst_n), .adc_raw_i(adc_raw),
    .spi_done_i(spi_done), .pll_locked_i(pll_locked), .trig_level_i(trig_level),
    .trig_ch_en_i(trig_ch_en), .asg_trig_i(asg_trig), .daisy_mode_i(daisy_mode),
    .daisy_dat_i(daisy_dat), .can_on_i(can_on), .can0_tx_i(can0_tx), .can1_tx_i(can1_tx),
    .exp_p_i(exp_p), .exp_n_i(exp_n), .exp_n_out_i(exp_n_out), .exp_n_dir_i(exp_n_dir),
    .adc_dat_o(adc_dat), .adc_vld_o(adc_vld), .scope_trig_o(scope_trig),
    .trig_ext_o(trig_ext), .trig_out_o(trig_out), .exp_n_o(exp_n_q),
    .exp_n_oe_o(exp_n_oe), .can0_rx_o(can0_rx), .can1_rx_o(can1_rx)
  );

  // neg slope offset binary to two's complement keeps the msb and flips the rest
  function automatic bit [`ADC_DW-1:0] to_twos(bit [`ADC_DW-1:0] r);
    return r ^ {1'b0, {(`ADC_DW-1){1'b1}}};
  endfunction

  task automatic copy_entry(int dst, int src);
    raw_a[dst] = raw_a[src];
    lvl_a[dst] = lvl_a[src];
    en_a[dst] = en_a[src];
    md_a[dst] = md_a[src];
    dz_a[dst] = dz_a[src];
    asg_a[dst] = asg_a[src];
    spi_a[dst] = spi_a[src];
    pll_a[dst] = pll_a[src];
    p_a[dst] = p_a[src];
    no_a[dst] = no_a[src];
    nd_a[dst] = nd_a[src];
    can_a[dst] = can_a[src];
    c0_a[dst] = c0_a[src];
    c1_a[dst] = c1_a[src];
  endtask

  task automatic load_vectors();
    int fd, cnt, j;
    string line;
    bit [31:0] f [18];
    fd = $fopen("adc_fe_input.txt", "r");
    file_ok = (fd != 0);
    while (file_ok && !$feof(fd)) begin
      if ($fgets(line, fd) && line.len() > 1 && line[0] != 8'h23) begin  // skip # lines
        cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
          f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11],
          f[12], f[13], f[14], f[15], f[16], f[17]);
        if (cnt == 18) begin
          j = OFS + n_vec;
          for (int c = 0; c < `ADC_CHN; c++) begin
            raw_a[j][c] = f[c];
          end
          lvl_a[j] = f[4];
          en_a[j] = f[5];
          md_a[j] = f[6];
          dz_a[j] = f[7];
          asg_a[j] = f[8];
          spi_a[j] = f[9];
          pll_a[j] = f[10];
          p_a[j] = f[11];
          no_a[j] = f[12];
          nd_a[j] = f[13];
          can_a[j] = f[14];
          c0_a[j] = f[15];
          c1_a[j] = f[16];
          flag_a[j] = f[17];
          has_flag[j] = 1'b1;
          n_vec++;
        end
      end
    end
    if (file_ok) begin
      $fclose(fd);
    end
  endtask

  // random raw codes on top of the last file line
  // the tail raises the threshold and masks every channel
  task automatic add_random();
    int j;
    for (int r = 0; r < NRAND + NDRAIN; r++) begin
      j = OFS + n_vec + r;
      copy_entry(j, j - 1);
      for (int c = 0; c < `ADC_CHN; c++) begin
        if (r < NRAND) begin
          raw_a[j][c] = $urandom;
        end else if (r == NRAND) begin
          raw_a[j][c] = 14'h3000;  // well under the level
        end else if (r == NRAND + 1) begin
          raw_a[j][c] = 14'h1bff;  // above zero, still under the level
        end else begin
          raw_a[j][c] = 14'h1000;  // crossing, then held
        end
      end
      if (r >= NRAND) begin
        lvl_a[j] = DRAIN_LVL;
        en_a[j] = 4'h0;  // crossing must not reach the scope
      end
    end
    n_cyc = n_vec + NRAND + NDRAIN;
  endtask

  // rising crossing per sample with history from valid samples only
  task automatic compute_cross();
    bit below_q [`ADC_CHN];
    bit below;
    int lj;
    for (int c = 0; c < `ADC_CHN; c++) begin
      below_q[c] = 1'b0;
    end
    for (int j = OFS; j < OFS + n_cyc; j++) begin
      lj = (j + 3 < OFS + n_cyc) ? j + 3 : OFS + n_cyc - 1;  // level seen at compare
      for (int c = 0; c < `ADC_CHN; c++) begin
        below = $signed(to_twos(raw_a[j][c])) < $signed(lvl_a[lj]);
        cross_a[j][c] = spi_a[j] & pll_a[j] & below_q[c] & ~below;
        if (spi_a[j] & pll_a[j]) below_q[c] = below;
      end
    end
  endtask

  task automatic check_val(string name, logic [31:0] got, logic [31:0] exp);
    n_checks++;
    assert (got === exp) else begin
      n_err++;
      $display("MISMATCH %0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic drive_vec(int j);
    for (int c = 0; c < `ADC_CHN; c++) begin
      adc_raw[c] <= raw_a[j][c];
    end
    trig_level <= lvl_a[j];
    trig_ch_en <= en_a[j];
    daisy_mode <= md_a[j];
    daisy_dat <= dz_a[j];
    asg_trig <= asg_a[j];
    spi_done <= spi_a[j];
    pll_locked <= pll_a[j];
    exp_p <= p_a[j];
    exp_n_out <= no_a[j];
    exp_n_dir <= nd_a[j];
    can_on <= can_a[j];
    can0_tx <= c0_a[j];
    can1_tx <= c1_a[j];
  endtask

  // outputs after edge k see inputs of cycle k-1 and earlier in the registers
  task automatic check_cycle(int j, int k);
    bit s_exp, o_exp;
    bit [10:0] n_exp, oe_exp;
    s_exp = |(cross_a[j-5] & en_a[j-1]);
    o_exp = md_a[j-1][2] ? asg_a[j-1] : s_exp;
    n_exp = no_a[j];
    oe_exp = nd_a[j];
    if (md_a[j][1]) begin
      n_exp[`TRIG_PIN] = o_exp;
      oe_exp[`TRIG_PIN] = 1'b0;
    end
    if (can_a[j]) begin
      n_exp[`CAN0_PIN] = c0_a[j];
      n_exp[`CAN1_PIN] = c1_a[j];
      oe_exp[`CAN0_PIN] = 1'b1;
      oe_exp[`CAN1_PIN] = 1'b1;
    end
    check_val("adc_vld_o", adc_vld, spi_a[j-3] & pll_a[j-3]);
    for (int c = 0; c < `ADC_CHN; c++) begin
      if (k >= 3) begin
        check_val($sformatf("adc_dat_o[%0d]", c), $unsigned(adc_dat[c]),
                  to_twos(raw_a[j-3][c]));
      end
    end
    check_val("trig_ch", dut0.trig_ch, has_flag[j-4] ? flag_a[j-4] : cross_a[j-4]);
    check_val("scope_trig_o", scope_trig, s_exp);
    check_val("trig_ext_o", trig_ext, p_a[j-1][`TRIG_PIN] & ~(md_a[j-1][0] & |dz_a[j-1]));
    check_val("trig_out_o", trig_out, o_exp);
    check_val("exp_n_o", exp_n_q, n_exp);
    check_val("exp_n_oe_o", exp_n_oe, oe_exp);
    check_val("can0_rx_o", can0_rx, can_a[j] & p_a[j][`CAN0_PIN]);
    check_val("can1_rx_o", can1_rx, can_a[j] & p_a[j][`CAN1_PIN]);
  endtask

  ////////////////////////////////////////////////// run limit
  always @(posedge adc_clk_01) begin
    if (rst_n) cyc_cnt++;
    if (cyc_cnt > limit) begin
      $display("timeout: run did not finish within %0d cycles", limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////// main sequence
  initial begin
    adc_raw = '0;
    trig_level = '0;
    trig_ch_en = '0;
    daisy_mode = '0;
    daisy_dat = '0;
    spi_done = 1'b0;
    pll_locked = 1'b0;
    asg_trig = 1'b0;
    can_on = 1'b0;
    can0_tx = 1'b0;
    can1_tx = 1'b0;
    exp_p = '0;
    exp_n = '0;
    exp_n_out = '0;
    exp_n_dir = '0;
    void'($urandom(32'h965b_d118));
    load_vectors();
    if (!file_ok || n_vec == 0) begin
      $display("could not read any vectors from adc_fe_input.txt");
      $display("TEST FAILED");
      $finish;
    end else begin
      add_random();
      compute_cross();
      limit = n_cyc + 20;
      @(posedge rst_n);
      for (int k = 0; k < n_cyc; k++) begin
        @(posedge adc_clk_01);
        drive_vec(OFS + k);
        @(negedge adc_clk_01);
        check_cycle(OFS + k, k);
      end
      $display("checks run %0d, errors %0d, assertion failures %0d",
               n_checks, n_err, dut0.u_checker.n_fail);
      if (n_err == 0 && dut0.u_checker.n_fail == 0) begin
        $display("TEST PASSED");
      end else begin
        $display("TEST FAILED");
      end
      $finish;
    end
  end

endmodule : adc_fe_tb

`default_nettype wire

//--- adc_fe_top.sv
// four channel ADC front end top level
// capture, per channel conversion lanes, trigger routing and the
// expansion connector alternate function override

`timescale 1ns/100ps
`default_nettype none

`include "adc_fe_macros.svh"

module adc_fe_top (
  input  logic                                 adc_clk_01,
  input  logic                                 rst_n_i,
  // converter side
  input  adc_fe_pkg::adc_raw_t [`ADC_CHN-1:0]  adc_raw_i,
  input  logic                                 spi_done_i,
  input  logic                                 pll_locked_i,
  // trigger setup
  input  adc_fe_pkg::adc_smp_t                 trig_level_i,
  input  logic [`ADC_CHN-1:0]                  trig_ch_en_i,
  input  logic                                 asg_trig_i,
  input  adc_fe_pkg::daisy_mode_t              daisy_mode_i,
  input  logic [`DAISY_DW-1:0]                 daisy_dat_i,
  // CAN
  input  logic                                 can_on_i,
  input  logic                                 can0_tx_i,
  input  logic                                 can1_tx_i,
  // expansion connector
  input  logic [`EXP_DW-1:0]                   exp_p_i,
  input  logic [`EXP_DW-1:0]                   exp_n_i,
  input  logic [`EXP_DW-1:0]                   exp_n_out_i,
  input  logic [`EXP_DW-1:0]                   exp_n_dir_i,
  // samples
  output adc_fe_pkg::adc_smp_t [`ADC_CHN-1:0]  adc_dat_o,
  output logic                                 adc_vld_o,
  // triggers
  output logic                                 scope_trig_o,
  output logic                                 trig_ext_o,
  output logic                                 trig_out_o,
  output logic [`EXP_DW-1:0]                   exp_n_o,
  output logic [`EXP_DW-1:0]                   exp_n_oe_o,
  output logic                                 can0_rx_o,
  output logic                                 can1_rx_o
);

  adc_fe_pkg::adc_raw_t [`ADC_CHN-1:0]  raw_q;    // captured words
  logic                                 raw_vld;
  logic [`ADC_CHN-1:0]                  smp_vld;  // per lane valid
  logic [`ADC_CHN-1:0]                  trig_ch;  // lane crossings
  logic                                 trig_pin; // external trigger level
  logic                                 trig_out; // back out to the pin mux

  //////////////////////////////////////////////////
  // sample path

  adc_capture i_capture (
    .adc_clk_01   (adc_clk_01),
    .rst_n_i      (rst_n_i),
    .adc_raw_i    (adc_raw_i),
    .spi_done_i   (spi_done_i),
    .pll_locked_i (pll_locked_i),
    .raw_o        (raw_q),
    .raw_vld_o    (raw_vld)
  );

  for (genvar i = 0; i < `ADC_CHN; i++) begin : g_lane
    adc_lane i_lane (
      .adc_clk_01   (adc_clk_01),
      .rst_n_i      (rst_n_i),
      .raw_i        (raw_q[i]),
      .raw_vld_i    (raw_vld),      // shared validity
      .trig_level_i (trig_level_i),
      .smp_o        (adc_dat_o[i]),
      .smp_vld_o    (smp_vld[i]),
      .trig_ch_o    (trig_ch[i])
    );
  end

  assign adc_vld_o = smp_vld[0];  // all lanes move in step

  //////////////////////////////////////////////////
  // triggers and pins

  trig_router i_router (
    .adc_clk_01 (adc_clk_01), .rst_n_i (rst_n_i),
    .trig_ch_i (trig_ch), .trig_ch_en_i (trig_ch_en_i),
    .trig_pin_i (trig_pin), .asg_trig_i (asg_trig_i),
    .daisy_mode_i (daisy_mode_i), .daisy_dat_i (daisy_dat_i),
    .scope_trig_o (scope_trig_o), .trig_ext_o (trig_ext_o),
    .trig_out_o (trig_out)
  );

  assign trig_out_o = trig_out;

  exp_pin_mux i_pin_mux (
    .exp_p_i (exp_p_i), .exp_n_i (exp_n_i),
    .exp_n_out_i (exp_n_out_i), .exp_n_dir_i (exp_n_dir_i),
    .trig_pin_alt_i (daisy_mode_i.trig_pin_alt), .trig_out_i (trig_out),
    .can_on_i (can_on_i), .can0_tx_i (can0_tx_i), .can1_tx_i (can1_tx_i),
    .exp_n_o (exp_n_o), .exp_n_oe_o (exp_n_oe_o), .trig_pin_o (trig_pin),
    .can0_rx_o (can0_rx_o), .can1_rx_o (can1_rx_o)
  );

endmodule : adc_fe_top

`default_nettype wire

//--- adc_lane.sv
// one ADC channel lane
// offset binary to two's complement, two register stages and a
// rising level-crossing trigger against the shared threshold

`timescale 1ns/100ps
`default_nettype none

`include "adc_fe_macros.svh"

module adc_lane (
  input  logic                  adc_clk_01,
  input  logic                  rst_n_i,
  input  adc_fe_pkg::adc_raw_t  raw_i,         // from capture stage
  input  logic                  raw_vld_i,
  input  adc_fe_pkg::adc_smp_t  trig_level_i,  // shared threshold
  output adc_fe_pkg::adc_smp_t  smp_o,
  output logic                  smp_vld_o,
  output logic                  trig_ch_o      // one cycle per crossing
);

  adc_fe_pkg::adc_smp_t  smp_r;     // first stage
  logic                  smp_vld_r;
  logic                  below_q;   // previous valid sample under level
  logic                  below;     // current sample under level

  //////////////////////////////////////////////////
  // code conversion and pipeline

  // neg slope offset binary: keep msb, flip the rest
  always_ff @(posedge adc_clk_01 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      smp_r     <= '0;
      smp_vld_r <= 1'b0;
      smp_o     <= '0;
      smp_vld_o <= 1'b0;
    end else begin
      smp_r     <= {raw_i[`ADC_DW-1], ~raw_i[`ADC_DW-2:0]};
      smp_vld_r <= raw_vld_i;
      smp_o     <= smp_r;      // second stage
      smp_vld_o <= smp_vld_r;  // valid rides along
    end
  end

  //////////////////////////////////////////////////
  // level crossing

  assign below = (smp_o < trig_level_i);  // signed compare

  always_ff @(posedge adc_clk_01 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      below_q   <= 1'b0;  // no history, first sample cannot fire
      trig_ch_o <= 1'b0;
    end else begin
      trig_ch_o <= smp_vld_o & below_q & ~below;
      if (smp_vld_o) begin
        below_q <= below;  // only valid samples count as history
      end
    end
  end

endmodule : adc_lane

`default_nettype wire

//--- exp_pin_mux.sv
// expansion connector alternate functions
// overrides n side bits for the trigger pin and CAN transmit,
// and picks the trigger and gated CAN receive levels off the p side

`timescale 1ns/100ps
`default_nettype none

`include "adc_fe_macros.svh"

module exp_pin_mux (
  input  logic [`EXP_DW-1:0]  exp_p_i,      // p side pin levels
  input  logic [`EXP_DW-1:0]  exp_n_i,      // n side pin levels
  input  logic [`EXP_DW-1:0]  exp_n_out_i,  // user drive value
  input  logic [`EXP_DW-1:0]  exp_n_dir_i,  // user direction, 1 drives
  input  logic                trig_pin_alt_i,
  input  logic                trig_out_i,
  input  logic                can_on_i,
  input  logic                can0_tx_i,
  input  logic                can1_tx_i,
  output logic [`EXP_DW-1:0]  exp_n_o,
  output logic [`EXP_DW-1:0]  exp_n_oe_o,
  output logic                trig_pin_o,
  output logic                can0_rx_o,
  output logic                can1_rx_o
);

  logic [`EXP_DW-1:0] alt_en;   // bit taken by alternate function
  logic [`EXP_DW-1:0] alt_val;  // alternate drive value
  logic [`EXP_DW-1:0] alt_oe;   // alternate direction

  //////////////////////////////////////////////////
  // n side override

  always_comb begin
    alt_en  = '0;
    alt_val = '0;
    alt_oe  = '0;
    alt_en [`TRIG_PIN] = trig_pin_alt_i;
    alt_val[`TRIG_PIN] = trig_out_i;
    alt_en [`CAN0_PIN] = can_on_i;
    alt_val[`CAN0_PIN] = can0_tx_i;
    alt_oe [`CAN0_PIN] = 1'b1;  // CAN tx always drives
    alt_en [`CAN1_PIN] = can_on_i;
    alt_val[`CAN1_PIN] = can1_tx_i;
    alt_oe [`CAN1_PIN] = 1'b1;
  end

  assign exp_n_o    = (alt_en & alt_val) | (~alt_en & exp_n_out_i);
  assign exp_n_oe_o = (alt_en & alt_oe)  | (~alt_en & exp_n_dir_i);

  //////////////////////////////////////////////////
  // receive side
  assign trig_pin_o = exp_p_i[`TRIG_PIN];
  assign can0_rx_o  = can_on_i & exp_p_i[`CAN0_PIN];  // idle low when off
  assign can1_rx_o  = can_on_i & exp_p_i[`CAN1_PIN];

endmodule : exp_pin_mux

`default_nettype wire

//--- files.f
+incdir+.
adc_fe_pkg.sv
adc_capture.sv
adc_lane.sv
trig_router.sv
exp_pin_mux.sv
adc_fe_top.sv
tb_clkgen.sv
adc_fe_checker.sv
adc_fe_tb.sv

//--- tb_clkgen.sv
// testbench clock and reset source
// 100 ns clock, reset held low for three rising edges

`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
  output logic adc_clk_01,
  output logic rst_n_o
);

  initial begin
    adc_clk_01 = 1'b0;
    forever #50 adc_clk_01 = ~adc_clk_01;  // 100 ns period
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge adc_clk_01);
    @(negedge adc_clk_01);  // release away from the active edge
    rst_n_o = 1'b1;
  end

endmodule : tb_clkgen

`default_nettype wire

//--- trig_router.sv
// trigger router
// merges the enabled lane triggers into the scope trigger, gates the
// external trigger in daisy sync mode and picks the trigger sent out

`timescale 1ns/100ps
`default_nettype none

`include "adc_fe_macros.svh"

module trig_router (
  input  logic                      adc_clk_01,
  input  logic                      rst_n_i,
  input  logic [`ADC_CHN-1:0]       trig_ch_i,     // lane crossing pulses
  input  logic [`ADC_CHN-1:0]       trig_ch_en_i,  // per lane enable
  input  logic                      trig_pin_i,    // external trigger level
  input  logic                      asg_trig_i,    // generator trigger
  input  adc_fe_pkg::daisy_mode_t   daisy_mode_i,
  input  logic [`DAISY_DW-1:0]      daisy_dat_i,   // received daisy word
  output logic                      scope_trig_o,
  output logic                      trig_ext_o,
  output logic                      trig_out_o
);

  logic scope_trig;  // any enabled lane fired
  logic daisy_trig;  // something came in on the chain
  logic ext_gate;    // block local external trigger

  //////////////////////////////////////////////////
  // combine

  assign scope_trig = |(trig_ch_i & trig_ch_en_i);
  assign daisy_trig = |daisy_dat_i;

  // in sync mode the chain owns triggering, the local pin
  // is ignored while a word is arriving
  assign ext_gate   = daisy_mode_i.sync_en & daisy_trig;

  //////////////////////////////////////////////////
  // output registers

  always_ff @(posedge adc_clk_01 or negedge rst_n_i) begin
    if (!rst_n_i) begin
      scope_trig_o <= 1'b0;
      trig_ext_o   <= 1'b0;
      trig_out_o   <= 1'b0;
    end else begin
      scope_trig_o <= scope_trig;
      trig_ext_o   <= trig_pin_i & ~ext_gate;
      // out to other boards, generator or scope
      if (daisy_mode_i.trig_out_asg) begin
        trig_out_o <= asg_trig_i;
      end else begin
        trig_out_o <= scope_trig;  // same cycle as scope_trig_o
      end
    end
  end

endmodule : trig_router

`default_nettype wire
